// ==== logic/rv_core_pkg.sv ====
// RV64 core shared definitions
package rv_core_pkg;

    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int ALU_OP_W   = 4;
    localparam int TRAP_W     = 2;

    localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [6:0]  F7_ALT      = 7'b0100000; // sub / sra
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU   = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRA    = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd9;
    localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd10; // lui

    localparam logic [TRAP_W-1:0] TRAP_NONE    = 2'd0;
    localparam logic [TRAP_W-1:0] TRAP_EBREAK  = 2'd1;
    localparam logic [TRAP_W-1:0] TRAP_ILLEGAL = 2'd2;

    // one instruction word, several decodings
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r_view;
        struct packed {
            logic [11:0]           imm12;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i_view;
        struct packed {
            logic [19:0]           imm20;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } u_view;
        logic [31:0] raw;
    } inst_word_u;

endpackage

// ==== logic/core_buses.sv ====
// Pipeline stage buses
`timescale 1ns/1ps

// decode to execute
interface exec_bus_if import rv_core_pkg::*; ();
    logic                  valid;
    logic                  ready;
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rd;
    logic                  wen;
    logic [ALU_OP_W-1:0]   alu_op;
    logic [XLEN-1:0]       op_a;
    logic [XLEN-1:0]       op_b;
    logic [TRAP_W-1:0]     trap;

    modport decode_mp (output valid, pc, rd, wen, alu_op, op_a, op_b, trap, input ready);
    modport exec_mp (input valid, pc, rd, wen, alu_op, op_a, op_b, trap, output ready);
endinterface

// execute to writeback
interface retire_bus_if import rv_core_pkg::*; ();
    logic                  valid;
    logic                  ready;
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rd;
    logic                  wen;
    logic [XLEN-1:0]       result;
    logic [TRAP_W-1:0]     trap;

    modport exec_mp (output valid, pc, rd, wen, result, trap, input ready);
    modport wb_mp (input valid, pc, rd, wen, result, trap, output ready);
    // decode watches the execute register for hazards
    modport mon_mp (input valid, rd, wen);
endinterface

// register file read ports
interface regread_if import rv_core_pkg::*; ();
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;

    modport dec_mp (output rs1_addr, rs2_addr, input rs1_data, rs2_data);
    modport rf_mp (input rs1_addr, rs2_addr, output rs1_data, rs2_data);
endinterface

// ==== logic/inst_buffer.sv ====
// Instruction input buffer
`timescale 1ns/1ps

module inst_buffer import rv_core_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            inst_valid_i,
    output logic            inst_ready_o,
    input  logic [31:0]     inst_i,
    output logic            buf_valid_o,
    input  logic            buf_ready_i,
    output inst_word_u      buf_inst_o,
    output logic [XLEN-1:0] buf_pc_o
);

    logic            full;
    logic            open_q; // low for the first cycle out of reset
    logic [XLEN-1:0] pc_next;
    logic            accept;

    assign inst_ready_o = open_q & (~full | buf_ready_i); // refill while draining
    assign accept       = inst_valid_i & inst_ready_o;
    assign buf_valid_o  = full;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            full    <= 1'b0;
            open_q  <= 1'b0;
            pc_next <= RESET_PC;
        end else begin
            open_q <= 1'b1;
            if (accept) begin
                full    <= 1'b1;
                pc_next <= pc_next + XLEN'(4);
            end else if (buf_ready_i) begin
                full <= 1'b0; // decode took the word
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            buf_inst_o.raw <= inst_i;
            buf_pc_o       <= pc_next; // stamp with its pc
        end
    end

endmodule

// ==== logic/decode_stage.sv ====
// Decode stage
`timescale 1ns/1ps

module decode_stage import rv_core_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            buf_valid_i,
    output logic            buf_ready_o,
    input  inst_word_u      buf_inst_i,
    input  logic [XLEN-1:0] buf_pc_i,
    regread_if.dec_mp       rf,
    retire_bus_if.mon_mp    rt,
    exec_bus_if.decode_mp   ex
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [XLEN-1:0]     imm_i;
    logic [XLEN-1:0]     imm_u;
    logic                alt;
    logic                legal;
    logic                use_rs1;
    logic                use_rs2;
    logic                dec_wen;
    logic [ALU_OP_W-1:0] dec_op;
    logic [XLEN-1:0]     dec_b;
    logic [XLEN-1:0]     dec_a;
    logic [TRAP_W-1:0]   dec_trap;
    logic                rs1_busy;
    logic                rs2_busy;
    logic                hazard;
    logic                blocked; // set once a trapping word is taken
    logic                take;

    function automatic logic [ALU_OP_W-1:0] alu_sel(input logic [2:0] f3, input logic sel_alt);
        case (f3)
            3'b000:  return sel_alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return sel_alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode = buf_inst_i.r_view.opcode;
    assign funct3 = buf_inst_i.i_view.funct3;
    assign imm_i  = {{(XLEN-12){buf_inst_i.i_view.imm12[11]}}, buf_inst_i.i_view.imm12};
    assign imm_u  = {{(XLEN-32){buf_inst_i.u_view.imm20[19]}}, buf_inst_i.u_view.imm20, 12'b0};

    assign rf.rs1_addr = buf_inst_i.i_view.rs1;
    assign rf.rs2_addr = buf_inst_i.r_view.rs2;

    always_comb begin
        alt     = 1'b0;
        legal   = 1'b1;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        dec_wen = 1'b0;
        dec_a   = rf.rs1_data;
        dec_b   = rf.rs2_data;
        dec_trap = TRAP_NONE;
        case (opcode)
            OPC_OP: begin
                alt     = buf_inst_i.r_view.funct7 == F7_ALT;
                legal   = buf_inst_i.r_view.funct7 == 7'b0 ||
                          (alt && (funct3 == 3'b000 || funct3 == 3'b101));
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                dec_wen = 1'b1;
            end
            OPC_OP_IMM: begin
                alt     = funct3 == 3'b101 && buf_inst_i.i_view.imm12[10]; // srai, no subi
                if (funct3 == 3'b001)
                    legal = buf_inst_i.i_view.imm12[11:6] == 6'b0;
                else if (funct3 == 3'b101)
                    legal = buf_inst_i.i_view.imm12[11:6] inside {6'b000000, 6'b010000};
                use_rs1 = 1'b1;
                dec_wen = 1'b1;
                dec_b   = imm_i; // shifts use the low 6 bits
            end
            OPC_LUI: begin
                dec_wen = 1'b1;
                dec_b   = imm_u;
            end
            OPC_SYSTEM: begin
                legal    = buf_inst_i.raw == EBREAK_WORD;
                dec_trap = TRAP_EBREAK;
            end
            default: legal = 1'b0;
        endcase
        dec_op = (opcode == OPC_LUI) ? ALU_PASS_B : alu_sel(funct3, alt);
        if (!legal) begin
            dec_trap = TRAP_ILLEGAL;
            dec_wen  = 1'b0;
            use_rs1  = 1'b0;
            use_rs2  = 1'b0;
        end
    end

    // raw hazard against decode and execute output registers
    assign rs1_busy = rf.rs1_addr != '0 &&
                      ((ex.valid && ex.wen && ex.rd == rf.rs1_addr) ||
                       (rt.valid && rt.wen && rt.rd == rf.rs1_addr));
    assign rs2_busy = rf.rs2_addr != '0 &&
                      ((ex.valid && ex.wen && ex.rd == rf.rs2_addr) ||
                       (rt.valid && rt.wen && rt.rd == rf.rs2_addr));
    assign hazard   = buf_valid_i && ((use_rs1 && rs1_busy) || (use_rs2 && rs2_busy));

    assign buf_ready_o = ~blocked & ~hazard & (~ex.valid | ex.ready);
    assign take        = buf_valid_i & buf_ready_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ex.valid <= 1'b0;
            blocked  <= 1'b0;
        end else begin
            if (take)
                ex.valid <= 1'b1;
            else if (ex.ready)
                ex.valid <= 1'b0;
            if (take && dec_trap != TRAP_NONE)
                blocked <= 1'b1; // halt intake until reset
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            ex.pc     <= buf_pc_i;
            ex.rd     <= buf_inst_i.r_view.rd;
            ex.wen    <= dec_wen;
            ex.alu_op <= dec_op;
            ex.op_a   <= (opcode == OPC_LUI) ? '0 : dec_a;
            ex.op_b   <= dec_b;
            ex.trap   <= dec_trap;
        end
    end

endmodule

// ==== logic/exec_stage.sv ====
// Execute stage
`timescale 1ns/1ps

module exec_stage import rv_core_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_i,
    exec_bus_if.exec_mp   ex,
    retire_bus_if.exec_mp rt
);

    logic [XLEN-1:0] alu_res;
    logic [5:0]      shamt;
    logic            take;

    assign shamt   = ex.op_b[5:0];
    assign ex.ready = ~rt.valid | rt.ready;
    assign take    = ex.valid & ex.ready;

    always_comb begin
        case (ex.alu_op)
            ALU_ADD:    alu_res = ex.op_a + ex.op_b;
            ALU_SUB:    alu_res = ex.op_a - ex.op_b;
            ALU_SLL:    alu_res = ex.op_a << shamt;
            ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(ex.op_a) < $signed(ex.op_b)};
            ALU_SLTU:   alu_res = {{(XLEN-1){1'b0}}, ex.op_a < ex.op_b};
            ALU_XOR:    alu_res = ex.op_a ^ ex.op_b;
            ALU_SRL:    alu_res = ex.op_a >> shamt;
            ALU_SRA:    alu_res = $unsigned($signed(ex.op_a) >>> shamt);
            ALU_OR:     alu_res = ex.op_a | ex.op_b;
            ALU_AND:    alu_res = ex.op_a & ex.op_b;
            ALU_PASS_B: alu_res = ex.op_b; // lui
            default:    alu_res = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i)
            rt.valid <= 1'b0;
        else if (take)
            rt.valid <= 1'b1;
        else if (rt.ready)
            rt.valid <= 1'b0;
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            rt.pc     <= ex.pc;
            rt.rd     <= ex.rd;
            rt.wen    <= ex.wen;
            rt.result <= alu_res;
            rt.trap   <= ex.trap;
        end
    end

    // held item must not change until writeback takes it
    a_out_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        rt.valid && !rt.ready |=>
            rt.valid && $stable({rt.pc, rt.rd, rt.wen, rt.result, rt.trap}));

    // decode must never mark a trapping word as a write
    a_trap_no_wen: assert property (@(posedge clk_i) disable iff (rst_i)
        rt.valid && rt.trap != TRAP_NONE |-> !rt.wen);

endmodule

// ==== logic/writeback_stage.sv ====
// Writeback stage
`timescale 1ns/1ps

module writeback_stage import rv_core_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    retire_bus_if.wb_mp           rt,
    regread_if.rf_mp              rf,
    output logic                  retire_valid_o,
    input  logic                  retire_ready_i,
    output logic [XLEN-1:0]       retire_pc_o,
    output logic [REG_ADDR_W-1:0] retire_rd_o,
    output logic                  retire_wen_o,
    output logic [XLEN-1:0]       retire_data_o,
    output logic [TRAP_W-1:0]     retire_trap_o,
    output logic                  halted_o
);

    logic [XLEN-1:0] regs [NUM_REGS];
    logic            accept;
    logic            rf_we;

    assign rt.ready = ~halted_o & (~retire_valid_o | retire_ready_i);
    assign accept   = rt.valid & rt.ready;
    assign rf_we    = accept & rt.wen & (rt.rd != '0);

    assign rf.rs1_data = (rf.rs1_addr == '0) ? '0 : regs[rf.rs1_addr]; // x0 reads zero
    assign rf.rs2_data = (rf.rs2_addr == '0) ? '0 : regs[rf.rs2_addr];

    always_ff @(posedge clk_i) begin
        if (rf_we)
            regs[rt.rd] <= rt.result;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            retire_valid_o <= 1'b0;
            halted_o       <= 1'b0;
        end else begin
            if (accept)
                retire_valid_o <= 1'b1;
            else if (retire_ready_i)
                retire_valid_o <= 1'b0;
            if (accept && rt.trap != TRAP_NONE)
                halted_o <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            retire_pc_o   <= rt.pc;
            retire_rd_o   <= rt.rd;
            retire_wen_o  <= rt.wen;
            retire_data_o <= rt.result;
            retire_trap_o <= rt.trap;
        end
    end

    // x0 storage keeps its power-up contents
    a_x0_never_written: assert property (@(posedge clk_i) disable iff (rst_i)
        regs[0] === $past(regs[0]));

    a_quiet_after_halt: assert property (@(posedge clk_i) disable iff (rst_i)
        halted_o |=> !$rose(retire_valid_o));

    a_retire_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        retire_valid_o && !retire_ready_i |=> retire_valid_o &&
            $stable({retire_pc_o, retire_rd_o, retire_wen_o, retire_data_o, retire_trap_o}));

endmodule

// ==== logic/core_top.sv ====
// RV64 integer pipeline top
`timescale 1ns/1ps

module core_top import rv_core_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  inst_valid_i,
    output logic                  inst_ready_o,
    input  logic [31:0]           inst_i,
    output logic                  retire_valid_o,
    input  logic                  retire_ready_i,
    output logic [XLEN-1:0]       retire_pc_o,
    output logic [REG_ADDR_W-1:0] retire_rd_o,
    output logic                  retire_wen_o,
    output logic [XLEN-1:0]       retire_data_o,
    output logic [TRAP_W-1:0]     retire_trap_o,
    output logic                  halted_o
);

    logic            buf_valid;
    logic            buf_ready;
    inst_word_u      buf_inst;
    logic [XLEN-1:0] buf_pc;

    exec_bus_if   ex_bus ();
    retire_bus_if rt_bus ();
    regread_if    rf_bus ();

    inst_buffer u_inst_buffer (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .inst_valid_i (inst_valid_i),
        .inst_ready_o (inst_ready_o),
        .inst_i       (inst_i),
        .buf_valid_o  (buf_valid),
        .buf_ready_i  (buf_ready),
        .buf_inst_o   (buf_inst),
        .buf_pc_o     (buf_pc)
    );

    decode_stage u_decode_stage (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .buf_valid_i (buf_valid),
        .buf_ready_o (buf_ready),
        .buf_inst_i  (buf_inst),
        .buf_pc_i    (buf_pc),
        .rf          (rf_bus),
        .rt          (rt_bus), // hazard view of execute output
        .ex          (ex_bus)
    );

    exec_stage u_exec_stage (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .ex    (ex_bus),
        .rt    (rt_bus)
    );

    writeback_stage u_writeback_stage (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .rt             (rt_bus),
        .rf             (rf_bus),
        .retire_valid_o (retire_valid_o),
        .retire_ready_i (retire_ready_i),
        .retire_pc_o    (retire_pc_o),
        .retire_rd_o    (retire_rd_o),
        .retire_wen_o   (retire_wen_o),
        .retire_data_o  (retire_data_o),
        .retire_trap_o  (retire_trap_o),
        .halted_o       (halted_o)
    );

endmodule

// ==== verification/core_tb.sv ====
// Core pipeline testbench
`timescale 1ns/1ps

module core_tb import rv_core_pkg::*; ();

    localparam int HALF       = 10;
    localparam int WAIT_LIMIT = 2000; // cycles per wait loop

    typedef struct packed {
        logic [31:0]     word;
        logic [XLEN-1:0] pc;
    } sent_t;

    logic                  clk_i = 1'b0;
    logic                  rst_i;
    logic                  inst_valid_i;
    logic                  inst_ready_o;
    logic [31:0]           inst_i;
    logic                  retire_valid_o;
    logic                  retire_ready_i;
    logic [XLEN-1:0]       retire_pc_o;
    logic [REG_ADDR_W-1:0] retire_rd_o;
    logic                  retire_wen_o;
    logic [XLEN-1:0]       retire_data_o;
    logic [TRAP_W-1:0]     retire_trap_o;
    logic                  halted_o;

    sent_t                 exp_q[$]; // accepted words in program order
    logic [XLEN-1:0]       ref_regs [NUM_REGS];
    logic [XLEN-1:0]       next_pc;
    logic                  bp_on;    // random retire back-pressure
    logic                  aborted;
    int                    errors;
    int                    checks;
    int                    err_mark;
    sent_t                 cur;
    logic [REG_ADDR_W-1:0] e_rd;
    logic                  e_wen;
    logic [XLEN-1:0]       e_data;
    logic [TRAP_W-1:0]     e_trap;

    core_top UUT (.*);

    always #(HALF) clk_i = ~clk_i;

    always @(negedge clk_i) begin
        retire_ready_i = bp_on ? ($urandom_range(0, 3) != 0) : 1'b1;
    end

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    // legal words only, registers x0..x7 for plenty of hazards
    function automatic logic [31:0] rand_word();
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        int          kind;
        f3   = $urandom_range(0, 7);
        rd   = $urandom_range(0, 7);
        rs1  = $urandom_range(0, 7);
        rs2  = $urandom_range(0, 7);
        imm  = $urandom;
        kind = $urandom_range(0, 9);
        if (kind < 4)
            return r_word(((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1)) ? F7_ALT : 7'b0,
                          rs2, rs1, f3, rd);
        if (kind < 9) begin
            if (f3 == 3'd1)
                imm[11:6] = 6'b0;
            else if (f3 == 3'd5)
                imm[11:6] = $urandom_range(0, 1) ? 6'b010000 : 6'b0;
            return i_word(imm, rs1, f3, rd);
        end
        return u_word($urandom, rd);
    endfunction

    // expected effect of one word, applied to the model registers
    function automatic void ref_exec(input logic [31:0] w, output logic [REG_ADDR_W-1:0] rd,
                                     output logic wen, output logic [XLEN-1:0] res,
                                     output logic [TRAP_W-1:0] trap);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [2:0]      f3;
        logic [5:0]      sh;
        logic            alt;
        logic            ok;
        rd   = w[11:7];
        f3   = w[14:12];
        a    = ref_regs[w[19:15]];
        b    = ref_regs[w[24:20]];
        wen  = 1'b1;
        trap = TRAP_NONE;
        res  = '0;
        ok   = 1'b1;
        alt  = 1'b0;
        case (w[6:0])
            OPC_OP: begin
                alt = w[31:25] == F7_ALT;
                ok  = w[31:25] == 7'b0 || (alt && (f3 == 3'd0 || f3 == 3'd5));
            end
            OPC_OP_IMM: begin
                b   = {{(XLEN-12){w[31]}}, w[31:20]};
                alt = f3 == 3'd5 && w[30]; // no subi
                if (f3 == 3'd1)
                    ok = w[31:26] == 6'b0;
                else if (f3 == 3'd5)
                    ok = w[31:26] == 6'b0 || w[31:26] == 6'b010000;
            end
            OPC_LUI: ;
            OPC_SYSTEM: begin
                ok   = w == EBREAK_WORD;
                trap = TRAP_EBREAK;
                wen  = 1'b0;
            end
            default: ok = 1'b0;
        endcase
        sh = b[5:0];
        if (w[6:0] == OPC_LUI)
            res = {{(XLEN-32){w[31]}}, w[31:12], 12'b0};
        else
            case (f3)
                3'd0: res = alt ? a - b : a + b;
                3'd1: res = a << sh;
                3'd2: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                3'd3: res = (a < b) ? 64'd1 : 64'd0;
                3'd4: res = a ^ b;
                3'd5: begin
                    res = a >> sh;
                    if (alt && a[XLEN-1])
                        res = res | ~({XLEN{1'b1}} >> sh); // vacated bits take the sign
                end
                3'd6: res = a | b;
                default: res = a & b;
            endcase
        if (!ok) begin
            trap = TRAP_ILLEGAL;
            wen  = 1'b0;
        end
        if (wen && rd != '0)
            ref_regs[rd] = res;
    endfunction

    task automatic check_retire(input logic [XLEN-1:0] pc_exp,
                                input logic [REG_ADDR_W-1:0] rd_exp, input logic wen_exp,
                                input logic [XLEN-1:0] data_exp);
        checks++;
        if (retire_pc_o !== pc_exp || retire_rd_o !== rd_exp || retire_wen_o !== wen_exp ||
            retire_data_o !== data_exp || retire_trap_o !== TRAP_NONE) begin
            errors++;
            $display("FAILED %0t: pc %h rd %0d wen %b data %h trap %0d, expected %h %0d %b %h",
                     $time, retire_pc_o, retire_rd_o, retire_wen_o, retire_data_o,
                     retire_trap_o, pc_exp, rd_exp, wen_exp, data_exp);
        end
    endtask

    task automatic check_trap(input logic [XLEN-1:0] pc_exp, input logic [TRAP_W-1:0] trap_exp);
        checks++;
        if (retire_pc_o !== pc_exp || retire_trap_o !== trap_exp || retire_wen_o !== 1'b0) begin
            errors++;
            $display("FAILED %0t: trap pc %h code %0d wen %b, expected pc %h code %0d wen 0",
                     $time, retire_pc_o, retire_trap_o, retire_wen_o, pc_exp, trap_exp);
        end
    endtask

    task automatic verify_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    // compare every retire transfer with the model
    always @(posedge clk_i) begin
        if (!rst_i && retire_valid_o && retire_ready_i) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected retire at pc %h with no word outstanding", retire_pc_o);
            end else begin
                cur = exp_q.pop_front();
                ref_exec(cur.word, e_rd, e_wen, e_data, e_trap);
                if (e_trap != TRAP_NONE)
                    check_trap(cur.pc, e_trap);
                else
                    check_retire(cur.pc, e_rd, e_wen, e_data);
            end
        end
    end

    task automatic apply_reset();
        rst_i        = 1'b1;
        inst_valid_i = 1'b0;
        repeat (8) @(negedge clk_i);
        rst_i   = 1'b0;
        next_pc = RESET_PC;
        verify_flag("inst_ready_o after reset", inst_ready_o, 1'b0);
        verify_flag("retire_valid_o after reset", retire_valid_o, 1'b0);
        verify_flag("halted_o after reset", halted_o, 1'b0);
    endtask

    task automatic send_word(input logic [31:0] w, input int gap);
        int   waited;
        logic fire;
        waited = 0;
        fire   = 1'b0;
        repeat (gap) begin
            @(negedge clk_i);
            inst_valid_i = 1'b0;
        end
        @(negedge clk_i);
        inst_valid_i = 1'b1;
        inst_i       = w;
        while (!fire && !aborted) begin
            #(HALF - 1);
            fire = inst_ready_o; // sampled just before the edge
            @(posedge clk_i);
            if (!fire) begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    errors++;
                    aborted = 1'b1;
                    $display("timeout: the core never accepted word %h", w);
                end
                @(negedge clk_i);
            end
        end
        if (fire) begin
            exp_q.push_back('{word: w, pc: next_pc});
            next_pc += 4;
        end
    endtask

    task automatic drop_valid();
        @(negedge clk_i);
        inst_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && !aborted) begin
            @(negedge clk_i);
            waited++;
            if (waited > WAIT_LIMIT) begin
                errors++;
                aborted = 1'b1;
                $display("timeout: %0d words never retired", exp_q.size());
            end
        end
    endtask

    task automatic wait_halt();
        int waited;
        waited = 0;
        while (!halted_o && !aborted) begin
            @(negedge clk_i);
            waited++;
            if (waited > WAIT_LIMIT) begin
                errors++;
                aborted = 1'b1;
                $display("timeout: the core did not halt after a trapping word");
            end
        end
    endtask

    task automatic quiet_window();
        repeat (40) begin
            @(negedge clk_i);
            verify_flag("halted_o while halted", halted_o, 1'b1);
            verify_flag("inst_ready_o while halted", inst_ready_o, 1'b0);
            verify_flag("retire_valid_o while halted", retire_valid_o, 1'b0);
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s finished with %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    task automatic trap_halt(input logic [31:0] w);
        send_word(w, 0);
        @(negedge clk_i);
        inst_valid_i = 1'b1;
        inst_i       = i_word(12'd1, 5'd1, 3'd0, 5'd1); // must never retire
        wait_halt();
        wait_drain();
        quiet_window();
        inst_valid_i = 1'b0;
    endtask

    initial begin
        int i;
        void'($urandom(32'h8541));
        inst_valid_i   = 1'b0;
        inst_i         = '0;
        retire_ready_i = 1'b1;
        bp_on          = 1'b0;
        aborted        = 1'b0;
        errors         = 0;
        checks         = 0;
        err_mark       = 0;
        for (i = 0; i < NUM_REGS; i++)
            ref_regs[i] = '0;
        apply_reset();
        report_test("reset");

        send_word(i_word(12'hFFB, 5'd0, 3'd0, 5'd1), 0); // x1 = -5
        send_word(i_word(12'd3, 5'd0, 3'd0, 5'd2), 0);
        send_word(u_word(20'h80000, 5'd3), 0);           // sign bit of the upper half
        send_word(i_word(12'd63, 5'd0, 3'd0, 5'd4), 0);
        send_word(i_word(12'hFFF, 5'd0, 3'd0, 5'd8), 0);
        send_word(r_word(7'b0, 5'd2, 5'd1, 3'd0, 5'd10), 0);
        send_word(r_word(F7_ALT, 5'd2, 5'd1, 3'd0, 5'd11), 0);
        send_word(r_word(7'b0, 5'd4, 5'd2, 3'd1, 5'd12), 0);
        send_word(r_word(7'b0, 5'd2, 5'd1, 3'd2, 5'd13), 0);
        send_word(r_word(7'b0, 5'd2, 5'd1, 3'd3, 5'd14), 0);
        send_word(r_word(7'b0, 5'd3, 5'd1, 3'd4, 5'd15), 0);
        send_word(r_word(7'b0, 5'd4, 5'd3, 3'd5, 5'd16), 0);
        send_word(r_word(F7_ALT, 5'd4, 5'd3, 3'd5, 5'd17), 0);
        send_word(r_word(7'b0, 5'd2, 5'd1, 3'd6, 5'd18), 0);
        send_word(r_word(7'b0, 5'd3, 5'd1, 3'd7, 5'd19), 0);
        send_word(r_word(7'b0, 5'd1, 5'd3, 3'd2, 5'd20), 0);
        send_word(i_word(12'h800, 5'd1, 3'd0, 5'd21), 0);
        send_word(i_word(12'hFFC, 5'd1, 3'd2, 5'd22), 0);
        send_word(i_word(12'hFFF, 5'd2, 3'd3, 5'd23), 0);
        send_word(i_word(12'hFFF, 5'd1, 3'd4, 5'd24), 0);
        send_word(i_word(12'h7F0, 5'd2, 3'd6, 5'd25), 0);
        send_word(i_word(12'h5A5, 5'd8, 3'd7, 5'd26), 0);
        send_word(i_word(12'd63, 5'd8, 3'd1, 5'd27), 0);
        send_word(i_word(12'd63, 5'd8, 3'd5, 5'd28), 0);
        send_word(i_word(12'h43F, 5'd3, 3'd5, 5'd29), 0);
        send_word(i_word(12'h401, 5'd3, 3'd5, 5'd30), 0);
        send_word(i_word(12'd0, 5'd3, 3'd5, 5'd31), 0);
        send_word(u_word(20'hFFFFF, 5'd9), 0);
        send_word(u_word(20'h7FFFF, 5'd9), 0);
        send_word(i_word(12'd5, 5'd1, 3'd0, 5'd0), 0);   // write to x0 is dropped
        send_word(r_word(7'b0, 5'd1, 5'd1, 3'd6, 5'd0), 0);
        send_word(r_word(7'b0, 5'd0, 5'd0, 3'd0, 5'd5), 0);
        send_word(i_word(12'd0, 5'd0, 3'd0, 5'd5), 0);
        drop_valid();
        wait_drain();
        report_test("alu operations");

        send_word(i_word(12'd11, 5'd0, 3'd0, 5'd6), 0);
        for (i = 0; i < 8; i++)
            send_word(i_word(12'd7, 5'd6, 3'd0, 5'd6), 0); // each reads the last rd
        send_word(r_word(7'b0, 5'd6, 5'd6, 3'd0, 5'd7), 0);
        for (i = 0; i < 6; i++)
            send_word(r_word(F7_ALT, 5'd6, 5'd7, 3'd0, 5'd7), 0);
        for (i = 0; i < 4; i++)
            send_word(i_word(12'd3, 5'd7, 3'd1, 5'd7), 0);
        send_word(r_word(7'b0, 5'd7, 5'd0, 3'd4, 5'd9), 0); // hazard on rs2 only
        drop_valid();
        wait_drain();
        report_test("dependency chains");

        bp_on = 1'b1;
        for (i = 0; i < 300; i++)
            send_word(rand_word(), ($urandom_range(0, 3) == 0) ? $urandom_range(1, 3) : 0);
        drop_valid();
        wait_drain();
        bp_on = 1'b0;
        report_test("random stream");

        trap_halt(EBREAK_WORD);
        report_test("ebreak halt");
        apply_reset();
        trap_halt(32'h0000_000B); // custom-0 opcode is not supported
        report_test("illegal word halt");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== filelist.f ====
logic/rv_core_pkg.sv
logic/core_buses.sv
logic/inst_buffer.sv
logic/decode_stage.sv
logic/exec_stage.sv
logic/writeback_stage.sv
logic/core_top.sv
verification/core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - logic/rv_core_pkg.sv
  - logic/core_buses.sv
  - logic/inst_buffer.sv
  - logic/decode_stage.sv
  - logic/exec_stage.sv
  - logic/writeback_stage.sv
  - logic/core_top.sv
  - target: simulation
    files:
      - verification/core_tb.sv
